//--- filelist.f
+incdir+.
clint_pkg.sv
clint_ahb_regs.sv
clint_time_xfer.sv
clint_time_counter.sv
clint_top.sv
tb_clk_gen.sv
tb_clint.sv

//--- tb_clint.sv
//////////////////////////////////////////////////////////////////////
// CLINT testbench
// Runs AHB-Lite word transfers against the CLINT and checks MSIP,
// MTIMECMP, the MTIME crossing and both interrupts
//////////////////////////////////////////////////////////////////////

`include "clint_cfg.svh"

module tb_clint import clint_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // Upper bound in HCLK cycles for every wait loop
  localparam int TIMEOUT = 1000;

  logic       HCLK;
  logic       TIMECLK;
  logic       HRESETn;
  logic       hsel;
  bus_addr_t  haddr;
  logic       hwrite;
  logic [1:0] htrans;
  bus_word_t  hwdata;
  ahb_req_t   ahb;
  bus_word_t  hrdata;
  logic       hreadyout;
  logic       hresp;
  time_val_t  mtime;
  logic       sw_int;
  logic       timer_int;
  time_val_t  mtime_last;
  logic       time_written;
  int         errors = 0;

  // Only one slave on the bus, so HREADY is its own HREADYOUT
  assign ahb = {hsel, haddr, hwrite, htrans, hreadyout};

  tb_clk_gen clk_gen_i (
    .HCLK    (HCLK),
    .TIMECLK (TIMECLK),
    .HRESETn (HRESETn)
  );

  clint_top dut_i (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .TIMECLK   (TIMECLK),
    .ahb       (ahb),
    .hwdata    (hwdata),
    .hrdata    (hrdata),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .mtime     (mtime),
    .sw_int    (sw_int),
    .timer_int (timer_int)
  );

  //////////////////////////////////////////////////////////////////////
  // Error reporting and value checks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("sim failed");
    $fatal(1, "CLINT testbench stopped at the first error");
  endtask

  task automatic report_mismatch(input string test, input time_val_t exp, input time_val_t act);
    errors++;
    $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", test, exp, act);
    stop_run();
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR %s", what);
    stop_run();
  endtask

  task automatic check_eq(input string test, input time_val_t exp, input time_val_t act);
    assert (act === exp) else report_mismatch(test, exp, act);
  endtask

  // Passes when lo <= act < hi
  task automatic check_range(input string test, input time_val_t lo, input time_val_t hi,
                             input time_val_t act);
    assert (act >= lo && act < hi) else begin
      errors++;
      $display("MISMATCH %s: expected 0x%0h to 0x%0h, actual 0x%0h", test, lo, hi - 1, act);
      stop_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // AHB-Lite master
  //////////////////////////////////////////////////////////////////////

  // HREADYOUT comes from a register, so it is steady 1 ns after an edge
  task automatic wait_ready_high(input string what);
    int n;
    n = 0;
    while (hreadyout !== 1'b1) begin
      @(posedge HCLK);
      #1;
      n++;
      if (n > TIMEOUT) begin
        report_error({"HREADYOUT stayed low during ", what});
      end
    end
  endtask

  // Returns 1 ns after the edge that completes the current phase
  task automatic finish_phase(input string what);
    wait_ready_high(what);
    @(posedge HCLK);
    #1;
  endtask

  task automatic write_word(input bus_addr_t addr, input bus_word_t data);
    hsel   = 1'b1;
    haddr  = addr;
    hwrite = 1'b1;
    htrans = 2'b10;
    finish_phase("a write address phase");
    hsel   = 1'b0;
    htrans = 2'b00;
    hwdata = data;
    finish_phase("a write data phase");
  endtask

  task automatic read_word(input bus_addr_t addr, output bus_word_t data);
    hsel   = 1'b1;
    haddr  = addr;
    hwrite = 1'b0;
    htrans = 2'b10;
    finish_phase("a read address phase");
    hsel   = 1'b0;
    htrans = 2'b00;
    finish_phase("a read data phase");
    data = hrdata;
  endtask

  // The stall begins in the cycle right after the data phase
  task automatic write_mtime(input bus_addr_t addr, input bus_word_t data);
    write_word(addr, data);
    assert (hreadyout == 1'b0) else report_error("HREADYOUT did not drop after an MTIME write");
    wait_ready_high("the MTIME write handshake");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks that run on every HCLK edge
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    mtime_last <= mtime;
  end

  a_hresp_okay: assert property (@(posedge HCLK) disable iff (!HRESETn) hresp == 1'b0)
    else report_mismatch("hresp_okay", 64'd0, $sampled(hresp));

  // MTIME only moves backwards around a write of its own
  a_mtime_rising: assert property (@(posedge HCLK) disable iff (!HRESETn || time_written)
    mtime >= mtime_last)
    else report_mismatch("mtime_port", $sampled(mtime_last), $sampled(mtime));

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    bus_word_t v;
    bus_word_t lo;
    bus_word_t hi;
    bus_word_t r0;
    bus_word_t r1;
    time_val_t cmp;
    int        n;
    hsel         = 1'b0;
    haddr        = '0;
    hwrite       = 1'b0;
    htrans       = 2'b00;
    hwdata       = '0;
    time_written = 1'b0;
    void'($urandom(32'h99f4c1a4));

    n = 0;
    while (HRESETn !== 1'b1) begin
      @(posedge HCLK);
      n++;
      if (n > 20) begin
        report_error("HRESETn was never released");
      end
    end
    @(posedge HCLK);
    #1;

    // Reset values, MTIME >= 0 holds so the timer interrupt is pending
    check_eq("reset_hreadyout", 1, hreadyout);
    check_eq("reset_sw_int", 0, sw_int);
    check_eq("reset_timer_int", 1, timer_int);
    read_word(`CLINT_MSIP_OFS, r0);
    check_eq("reset_msip", 0, r0);
    read_word(`CLINT_MTIMECMP_LO_OFS, r0);
    check_eq("reset_mtimecmp_lo", 0, r0);
    read_word(`CLINT_MTIMECMP_HI_OFS, r0);
    check_eq("reset_mtimecmp_hi", 0, r0);

    // MSIP keeps bit 0 only
    repeat (4) begin
      v = $urandom();
      write_word(`CLINT_MSIP_OFS, v);
      check_eq("msip_sw_int", v[0], sw_int);
      read_word(`CLINT_MSIP_OFS, r0);
      check_eq("msip_readback", v[0], r0);
    end

    // MTIMECMP halves read back exactly
    lo = $urandom();
    hi = $urandom();
    write_word(`CLINT_MTIMECMP_LO_OFS, lo);
    write_word(`CLINT_MTIMECMP_HI_OFS, hi);
    read_word(`CLINT_MTIMECMP_LO_OFS, r0);
    check_eq("mtimecmp_lo", lo, r0);
    read_word(`CLINT_MTIMECMP_HI_OFS, r0);
    check_eq("mtimecmp_hi", hi, r0);
    read_word(16'h0004, r0);
    check_eq("unmapped_0004", 0, r0);
    read_word(16'h8000, r0);
    check_eq("unmapped_8000", 0, r0);
    read_word(16'hBFF4, r0);
    check_eq("unmapped_bff4", 0, r0);

    // MTIME write through the handshake, then it keeps counting
    lo = $urandom() % 32'hF000_0000;
    time_written = 1'b1;
    write_mtime(`CLINT_MTIME_HI_OFS, 32'd0);
    write_mtime(`CLINT_MTIME_LO_OFS, lo);
    repeat (4) @(posedge HCLK);
    #1;
    time_written = 1'b0;
    read_word(`CLINT_MTIME_LO_OFS, r0);
    check_range("mtime_lo_after_write", {32'd0, lo}, {32'd0, lo} + 64'd64, r0);
    read_word(`CLINT_MTIME_HI_OFS, r0);
    check_eq("mtime_hi_after_write", 0, r0);
    read_word(`CLINT_MTIME_LO_OFS, r0);
    read_word(`CLINT_MTIME_LO_OFS, r1);
    check_range("mtime_nondecreasing", r0, 64'h1_0000_0000, r1);

    // A compare of all ones can never be reached
    write_word(`CLINT_MTIMECMP_LO_OFS, 32'hFFFF_FFFF);
    write_word(`CLINT_MTIMECMP_HI_OFS, 32'hFFFF_FFFF);
    check_eq("cmp_max_timer_int", 0, timer_int);

    // Compare 40 counts ahead, high half first so it never lands below MTIME
    read_word(`CLINT_MTIME_LO_OFS, r0);
    read_word(`CLINT_MTIME_HI_OFS, r1);
    cmp = {r1, r0} + 64'd40;
    write_word(`CLINT_MTIMECMP_HI_OFS, cmp[63:32]);
    write_word(`CLINT_MTIMECMP_LO_OFS, cmp[31:0]);
    check_eq("cmp_ahead_timer_int", 0, timer_int);
    n = 0;
    while (timer_int !== 1'b1) begin
      @(posedge HCLK);
      #1;
      n++;
      if (n > TIMEOUT) begin
        report_error("timer_int never rose after MTIME passed MTIMECMP");
      end
    end
    read_word(`CLINT_MTIME_LO_OFS, r0);
    read_word(`CLINT_MTIME_HI_OFS, r1);
    check_range("mtime_at_timer_int", cmp, 64'hFFFF_FFFF_FFFF_FFFF, {r1, r0});

    if (errors == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      stop_run();
    end
  end

endmodule

//--- tb_clk_gen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset source
// HCLK at 4 ns, an unrelated TIMECLK at 10 ns, and HRESETn held low
// for the first two HCLK cycles
//////////////////////////////////////////////////////////////////////

module tb_clk_gen (
  output logic HCLK,
  output logic TIMECLK,
  output logic HRESETn
);

  timeunit 1ns;
  timeprecision 100ps;

  // Bus clock
  initial begin
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK;
  end

  // Time base clock, started off phase so its edges drift against HCLK
  initial begin
    TIMECLK = 1'b0;
    #1.3;
    forever #5 TIMECLK = ~TIMECLK;
  end

  // Released just after the second rising HCLK edge
  initial begin
    HRESETn = 1'b0;
    repeat (2) @(posedge HCLK);
    #1 HRESETn = 1'b1;
  end

endmodule

//--- clint_top.sv
//////////////////////////////////////////////////////////////////////
// CLINT top level
// Bus slave on HCLK, MTIME counter on TIMECLK, and the crossing
//////////////////////////////////////////////////////////////////////

module clint_top import clint_pkg::*; (
  input  logic      HCLK,
  input  logic      HRESETn,
  input  logic      TIMECLK,
  input  ahb_req_t  ahb,
  input  bus_word_t hwdata,
  output bus_word_t hrdata,
  output logic      hreadyout,
  output logic      hresp,
  output time_val_t mtime,
  output logic      sw_int,
  output logic      timer_int
);

  time_wr_t  wr;
  time_wr_t  wr_hold;
  logic      busy;
  logic      req;
  logic      ack;
  time_val_t time_gray;

  // Register slave, all in HCLK
  clint_ahb_regs regs_i (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .ahb        (ahb),
    .hwdata     (hwdata),
    .busy       (busy),
    .mtime_sync (mtime),
    .hrdata     (hrdata),
    .hreadyout  (hreadyout),
    .hresp      (hresp),
    .wr         (wr),
    .sw_int     (sw_int),
    .timer_int  (timer_int)
  );

  // HCLK half of the crossing
  clint_time_xfer xfer_i (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .wr         (wr),
    .ack        (ack),
    .time_gray  (time_gray),
    .req        (req),
    .wr_hold    (wr_hold),
    .busy       (busy),
    .mtime_sync (mtime)
  );

  // Counter in the TIMECLK domain
  clint_time_counter counter_i (
    .TIMECLK   (TIMECLK),
    .HRESETn   (HRESETn),
    .req       (req),
    .wr_hold   (wr_hold),
    .ack       (ack),
    .time_gray (time_gray)
  );

endmodule

//--- clint_time_counter.sv
//////////////////////////////////////////////////////////////////////
// CLINT MTIME counter
// Counts on TIMECLK, takes word writes through the req/ack handshake
// and drives the count out as a registered Gray value
//////////////////////////////////////////////////////////////////////

`include "clint_cfg.svh"

module clint_time_counter import clint_pkg::*; (
  input  logic      TIMECLK,
  input  logic      HRESETn,
  input  logic      req,
  input  time_wr_t  wr_hold,
  output logic      ack,
  output time_val_t time_gray
);

  logic [`CLINT_SYNC_STAGES-1:0] rst_sync_q;
  logic                          rst_n_t;
  logic [`CLINT_SYNC_STAGES-1:0] req_sync_q;
  logic                          req_sync;
  logic                          req_rise;
  time_val_t                     mtime_q;

  // Reset enters asynchronously but leaves in step with TIMECLK
  always_ff @(posedge TIMECLK or negedge HRESETn) begin
    if (!HRESETn) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[`CLINT_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign rst_n_t = rst_sync_q[`CLINT_SYNC_STAGES-1];

  // Bring req over from HCLK
  always_ff @(posedge TIMECLK or negedge rst_n_t) begin
    if (!rst_n_t) begin
      req_sync_q <= '0;
    end else begin
      req_sync_q <= {req_sync_q[`CLINT_SYNC_STAGES-2:0], req};
    end
  end

  assign req_sync = req_sync_q[`CLINT_SYNC_STAGES-1];

  // Ack is the synchronized req one cycle later, which also marks its edge
  assign req_rise = req_sync & ~ack;

  // Count by one, except for the cycle that takes the held write
  always_ff @(posedge TIMECLK or negedge rst_n_t) begin
    if (!rst_n_t) begin
      ack       <= 1'b0;
      mtime_q   <= '0;
      time_gray <= '0;
    end else begin
      ack <= req_sync;
      if (req_rise && wr_hold.we_lo) begin
        mtime_q[`CLINT_XLEN-1:0] <= wr_hold.data;
      end else if (req_rise && wr_hold.we_hi) begin
        mtime_q[63:`CLINT_XLEN] <= wr_hold.data;
      end else begin
        mtime_q <= mtime_q + 64'd1;
      end
      // Registered so that no glitch of the encoder reaches HCLK
      time_gray <= mtime_q ^ (mtime_q >> 1);
    end
  end

  // Outside of writes the Gray output flips at most one bit per cycle
  a_gray_step: assert property (@(posedge TIMECLK) disable iff (!rst_n_t)
    !$past(req_rise, 2) |-> $countones(time_gray ^ $past(time_gray)) <= 1);

endmodule

//--- clint_time_xfer.sv
//////////////////////////////////////////////////////////////////////
// CLINT HCLK side crossing
// Runs the req/ack write handshake toward the TIMECLK counter and
// brings the Gray coded time back into HCLK as binary
//////////////////////////////////////////////////////////////////////

`include "clint_cfg.svh"

module clint_time_xfer import clint_pkg::*; (
  input  logic      HCLK,
  input  logic      HRESETn,
  input  time_wr_t  wr,
  input  logic      ack,
  input  time_val_t time_gray,
  output logic      req,
  output time_wr_t  wr_hold,
  output logic      busy,
  output time_val_t mtime_sync
);

  localparam int TW = $bits(time_val_t);

  xfer_state_t                   state;
  logic                          wr_start;
  logic [`CLINT_SYNC_STAGES-1:0] ack_sync_q;
  logic                          ack_sync;
  time_val_t                     gray_sync_q [`CLINT_SYNC_STAGES];
  time_val_t                     gray_s;

  //////////////////////////////////////////////////////////////////////
  // Write handshake
  //////////////////////////////////////////////////////////////////////

  assign wr_start = wr.we_lo | wr.we_hi;

  // Ack comes from TIMECLK, so it passes a plain flop chain first
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      ack_sync_q <= '0;
    end else begin
      ack_sync_q <= {ack_sync_q[`CLINT_SYNC_STAGES-2:0], ack};
    end
  end

  assign ack_sync = ack_sync_q[`CLINT_SYNC_STAGES-1];

  // Raise req, wait for ack high, drop req, then wait for ack low
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state <= IDLE;
      req   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (wr_start) begin
            state <= REQ;
            req   <= 1'b1;
          end
        end
        REQ: begin
          if (ack_sync) begin
            state <= WAIT_ACK_LOW;
            req   <= 1'b0;
          end
        end
        WAIT_ACK_LOW: begin
          if (!ack_sync) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // The held write stays frozen until the handshake is back in IDLE
  always_ff @(posedge HCLK) begin
    if (state == IDLE && wr_start) begin
      wr_hold <= wr;
    end
  end

  // The bus slave stalls for as long as the handshake is running
  assign busy = (state != IDLE);

  //////////////////////////////////////////////////////////////////////
  // Time read-back
  //////////////////////////////////////////////////////////////////////

  // Gray code moves one bit per count, so each bit may sync on its own
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      for (int i = 0; i < `CLINT_SYNC_STAGES; i++) begin
        gray_sync_q[i] <= '0;
      end
    end else begin
      gray_sync_q[0] <= time_gray;
      for (int i = 1; i < `CLINT_SYNC_STAGES; i++) begin
        gray_sync_q[i] <= gray_sync_q[i-1];
      end
    end
  end

  assign gray_s = gray_sync_q[`CLINT_SYNC_STAGES-1];

  // Each binary bit is its Gray bit xor the binary bit above it
  always_comb begin
    mtime_sync[TW-1] = gray_s[TW-1];
    for (int i = TW - 2; i >= 0; i--) begin
      mtime_sync[i] = gray_s[i] ^ mtime_sync[i+1];
    end
  end

  // Req may only drop once the counter has acknowledged it
  a_req_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $fell(req) |-> $past(ack_sync));

  // The counter samples wr_hold at any time while req is up
  a_hold_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (req && $past(req)) |-> $stable(wr_hold));

endmodule

//--- clint_ahb_regs.sv
//////////////////////////////////////////////////////////////////////
// CLINT AHB-Lite register slave
// Holds MSIP and MTIMECMP, returns read data with no wait states,
// raises the interrupts and stalls the bus during MTIME writes
//////////////////////////////////////////////////////////////////////

`include "clint_cfg.svh"

module clint_ahb_regs import clint_pkg::*; (
  input  logic      HCLK,
  input  logic      HRESETn,
  input  ahb_req_t  ahb,
  input  bus_word_t hwdata,
  input  logic      busy,
  input  time_val_t mtime_sync,
  output bus_word_t hrdata,
  output logic      hreadyout,
  output logic      hresp,
  output time_wr_t  wr,
  output logic      sw_int,
  output logic      timer_int
);

  logic      addr_valid;
  bus_addr_t addr_word;
  logic      dph_wr;
  bus_addr_t dph_addr;
  logic      wr_en;
  logic      msip_q;
  logic      msip_nxt;
  time_val_t mtimecmp_q;
  time_val_t mtimecmp_nxt;
  bus_word_t rd_mux;

  //////////////////////////////////////////////////////////////////////
  // Address phase
  //////////////////////////////////////////////////////////////////////

  // A transfer starts when selected, the bus is ready and HTRANS is not IDLE
  assign addr_valid = ahb.sel & ahb.ready & (ahb.trans != 2'b00);

  // Every access is a word, so the low address bits are ignored
  assign addr_word = {ahb.addr[15:2], 2'b00};

  // Keep the write flag and offset for the data phase that follows
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dph_wr   <= 1'b0;
      dph_addr <= '0;
    end else if (ahb.ready) begin
      dph_wr   <= addr_valid & ahb.write;
      dph_addr <= addr_word;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data phase and registers
  //////////////////////////////////////////////////////////////////////

  // The stall only ends once the MTIME handshake is back to idle
  assign hreadyout = ~busy;
  assign hresp     = 1'b0;

  // A write lands only when its data phase completes
  assign wr_en = dph_wr & hreadyout;

  // Next register values, so a read right behind a write sees new data
  always_comb begin
    msip_nxt     = msip_q;
    mtimecmp_nxt = mtimecmp_q;
    if (wr_en) begin
      case (dph_addr)
        `CLINT_MSIP_OFS:        msip_nxt = hwdata[0];
        `CLINT_MTIMECMP_LO_OFS: mtimecmp_nxt[`CLINT_XLEN-1:0] = hwdata;
        `CLINT_MTIMECMP_HI_OFS: mtimecmp_nxt[63:`CLINT_XLEN] = hwdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '0;
    end else begin
      msip_q     <= msip_nxt;
      mtimecmp_q <= mtimecmp_nxt;
    end
  end

  // MTIME lives in the TIMECLK domain, so its writes go out as a pulse
  always_comb begin
    wr.we_lo = wr_en & (dph_addr == `CLINT_MTIME_LO_OFS);
    wr.we_hi = wr_en & (dph_addr == `CLINT_MTIME_HI_OFS);
    wr.data  = hwdata;
  end

  //////////////////////////////////////////////////////////////////////
  // Read data
  //////////////////////////////////////////////////////////////////////

  // Unmapped offsets read back as zero
  always_comb begin
    case (addr_word)
      `CLINT_MSIP_OFS:        rd_mux = {{(`CLINT_XLEN-1){1'b0}}, msip_nxt};
      `CLINT_MTIMECMP_LO_OFS: rd_mux = mtimecmp_nxt[`CLINT_XLEN-1:0];
      `CLINT_MTIMECMP_HI_OFS: rd_mux = mtimecmp_nxt[63:`CLINT_XLEN];
      `CLINT_MTIME_LO_OFS:    rd_mux = mtime_sync[`CLINT_XLEN-1:0];
      `CLINT_MTIME_HI_OFS:    rd_mux = mtime_sync[63:`CLINT_XLEN];
      default:                rd_mux = '0;
    endcase
  end

  // Captured in the address phase, presented in the next data phase
  always_ff @(posedge HCLK) begin
    if (addr_valid && !ahb.write) begin
      hrdata <= rd_mux;
    end
  end

  // Interrupts, compare is unsigned on the synchronized time
  assign sw_int    = msip_q;
  assign timer_int = (mtime_sync >= mtimecmp_q);

  // The crossing must be idle before another MTIME write is issued
  a_no_wr_busy: assert property (@(posedge HCLK) disable iff (!HRESETn)
    busy |-> !(wr.we_lo || wr.we_hi));

  // No error response is ever given
  a_hresp_okay: assert property (@(posedge HCLK) disable iff (!HRESETn)
    hresp == 1'b0);

endmodule

//--- clint_pkg.sv
//////////////////////////////////////////////////////////////////////
// CLINT package
// Vector types, bus and write structs and the handshake states
//////////////////////////////////////////////////////////////////////

`include "clint_cfg.svh"

package clint_pkg;

  // One bus data word
  typedef logic [`CLINT_XLEN-1:0] bus_word_t;

  // Register offset inside the CLINT window
  typedef logic [15:0] bus_addr_t;

  // Full MTIME or MTIMECMP value
  typedef logic [63:0] time_val_t;

  // Address phase signals of the AHB-Lite request
  typedef struct packed {
    logic      sel;
    bus_addr_t addr;
    logic      write;
    logic [1:0] trans;
    logic      ready;
  } ahb_req_t;

  // A word write toward the MTIME counter, one enable per half
  typedef struct packed {
    logic      we_lo;
    logic      we_hi;
    bus_word_t data;
  } time_wr_t;

  // HCLK side of the four-phase req/ack handshake
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_ACK_LOW
  } xfer_state_t;

endpackage

//--- clint_cfg.svh
//////////////////////////////////////////////////////////////////////
// CLINT configuration
// Bus width, register map and synchronizer depth shared by the
// bus slave, the clock crossing and the timer counter
//////////////////////////////////////////////////////////////////////

`ifndef CLINT_CFG_SVH
`define CLINT_CFG_SVH

// Data width of the AHB-Lite bus, fixed for the 32-bit core
`define CLINT_XLEN 32

//////////////////////////////////////////////////////////////////////
// Register map, byte offsets inside the CLINT window
//////////////////////////////////////////////////////////////////////

// Software interrupt pending, only bit 0 is implemented
`define CLINT_MSIP_OFS        16'h0000
// Timer compare value, split into two words
`define CLINT_MTIMECMP_LO_OFS 16'h4000
`define CLINT_MTIMECMP_HI_OFS 16'h4004
// Free running time counter, split into two words
`define CLINT_MTIME_LO_OFS    16'hBFF8
`define CLINT_MTIME_HI_OFS    16'hBFFC

// Number of flops in every clock domain crossing synchronizer
`define CLINT_SYNC_STAGES 2

`endif
